/* rtl/exe_pkg.sv */
// Execute stage package with word types and ALU, branch and forwarding encodings
package exe_pkg;

  localparam int XLEN = 32;
  localparam int REG_IDX_W = 5;
  localparam int FUN3_W = 3;
  localparam int FUN7_W = 7;
  localparam int MEM_TO_REG_W = 2;

  typedef logic [XLEN-1:0] word_t;

  // Index 0 is the hardwired zero register
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Low bits follow fun3, bit 3 marks the fun7 variants
  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_SLL    = 4'b0001,
    ALU_SLT    = 4'b0010,
    ALU_SLTU   = 4'b0011,
    ALU_XOR    = 4'b0100,
    ALU_SRL    = 4'b0101,
    ALU_OR     = 4'b0110,
    ALU_AND    = 4'b0111,
    ALU_SUB    = 4'b1000,
    ALU_SRA    = 4'b1101,
    ALU_PASS_B = 4'b1111
  } alu_t;

  // Decode class from the main decoder
  typedef enum logic [1:0] {
    ALU_OP_ADD    = 2'b00,
    ALU_OP_BRANCH = 2'b01,
    ALU_OP_RTYPE  = 2'b10,
    ALU_OP_ITYPE  = 2'b11
  } alu_op_t;

  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,
    FWD_MEM  = 2'b01,
    FWD_WB   = 2'b10
  } fwd_sel_t;

  // RV32I branch fun3 codes
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_fun3_t;

endpackage : exe_pkg

/* rtl/common_cells.sv */
// Common pipeline cells: enabled registers with and without clear, and a 3-input mux
module n_bit_reg #(
  parameter int WIDTH = 8,
  parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             wen,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o
);

  logic [WIDTH-1:0] q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      q <= RESET_VALUE;
    end else if (wen) begin
      q <= data_i;
    end
  end

  assign data_o = q;

endmodule : n_bit_reg

module n_bit_reg_wclr #(
  parameter int WIDTH = 8,
  parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             wen,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o,
  input  logic             clear
);

  logic [WIDTH-1:0] q;

  // Clear wins over enable so a flushed slot turns into a bubble
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      q <= RESET_VALUE;
    end else if (clear) begin
      q <= '0;
    end else if (wen) begin
      q <= data_i;
    end
  end

  assign data_o = q;

endmodule : n_bit_reg_wclr

module mux3x1 #(
  parameter int WIDTH = 32
) (
  input  exe_pkg::fwd_sel_t sel,
  input  logic [WIDTH-1:0]  in0,
  input  logic [WIDTH-1:0]  in1,
  input  logic [WIDTH-1:0]  in2,
  output logic [WIDTH-1:0]  out
);
  import exe_pkg::*;

  logic sel0;
  logic sel1;
  logic sel2;

  assign sel0 = (sel == FWD_NONE);
  assign sel1 = (sel == FWD_MEM);
  assign sel2 = (sel == FWD_WB);

  // Unused code selects nothing
  assign out = ({WIDTH{sel0}} & in0) | ({WIDTH{sel1}} & in1) | ({WIDTH{sel2}} & in2);

endmodule : mux3x1

/* rtl/forwarding_unit.sv */
// Forwarding unit picking MEM or WB results for the two source operands
module forwarding_unit (
  input  exe_pkg::reg_idx_t rs1,
  input  exe_pkg::reg_idx_t rs2,
  input  exe_pkg::reg_idx_t mem_fwd_rd,
  input  logic              mem_fwd_reg_write,
  input  exe_pkg::reg_idx_t wb_rd,
  input  logic              wb_reg_write,
  output exe_pkg::fwd_sel_t fwd_a,
  output exe_pkg::fwd_sel_t fwd_b
);
  import exe_pkg::*;

  // MEM is younger than WB so it wins
  function automatic fwd_sel_t fwd_select(
    input reg_idx_t src,
    input reg_idx_t mem_rd,
    input logic     mem_we,
    input reg_idx_t wb_dst,
    input logic     wb_we
  );
    fwd_sel_t sel;
    sel = FWD_NONE;
    if (mem_we && (mem_rd != '0) && (mem_rd == src)) begin
      sel = FWD_MEM;
    end else if (wb_we && (wb_dst != '0) && (wb_dst == src)) begin
      sel = FWD_WB;
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a = fwd_select(rs1, mem_fwd_rd, mem_fwd_reg_write, wb_rd, wb_reg_write);
    fwd_b = fwd_select(rs2, mem_fwd_rd, mem_fwd_reg_write, wb_rd, wb_reg_write);
  end

endmodule : forwarding_unit

/* rtl/alu_control.sv */
// ALU control decoding alu_op, fun3 and fun7 into one ALU operation
module alu_control (
  input  exe_pkg::alu_op_t            alu_op,
  input  logic [exe_pkg::FUN3_W-1:0]  fun3,
  input  logic [exe_pkg::FUN7_W-1:0]  fun7,
  input  logic                        lui,
  output exe_pkg::alu_t               alu_sel
);
  import exe_pkg::*;

  logic alt_itype;

  // alt is fun7 bit 5, already qualified by the caller
  function automatic alu_t decode_fun3(
    input logic [FUN3_W-1:0] f3,
    input logic              alt
  );
    alu_t op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // I-type immediates reuse the fun7 field, only srai looks at it
  assign alt_itype = fun7[5] & (fun3 == 3'b101);

  always_comb begin
    case (alu_op)
      ALU_OP_ADD: begin
        alu_sel = lui ? ALU_PASS_B : ALU_ADD;
      end
      ALU_OP_BRANCH: begin
        alu_sel = ALU_SUB;
      end
      ALU_OP_RTYPE: begin
        alu_sel = decode_fun3(fun3, fun7[5]);
      end
      ALU_OP_ITYPE: begin
        alu_sel = decode_fun3(fun3, alt_itype);
      end
      default: begin
        alu_sel = ALU_ADD;
      end
    endcase
  end

endmodule : alu_control

/* rtl/alu.sv */
// RV32I ALU with arithmetic, logic, shift and compare operations
module alu (
  input  exe_pkg::word_t op_a,
  input  exe_pkg::word_t op_b,
  input  exe_pkg::alu_t  alu_sel,
  output exe_pkg::word_t result
);
  import exe_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = op_b[4:0];
  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  always_comb begin
    case (alu_sel)
      ALU_ADD: begin
        result = op_a + op_b;
      end
      ALU_SUB: begin
        result = op_a - op_b;
      end
      ALU_SLL: begin
        result = op_a << shamt;
      end
      ALU_SLT: begin
        result = {{(XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        result = {{(XLEN-1){1'b0}}, lt_unsigned};
      end
      ALU_XOR: begin
        result = op_a ^ op_b;
      end
      ALU_SRL: begin
        result = op_a >> shamt;
      end
      ALU_SRA: begin
        result = word_t'($signed(op_a) >>> shamt);
      end
      ALU_OR: begin
        result = op_a | op_b;
      end
      ALU_AND: begin
        result = op_a & op_b;
      end
      ALU_PASS_B: begin
        result = op_b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule : alu

/* rtl/branch_unit.sv */
// Branch unit evaluating conditions and computing jump and branch targets
module branch_unit (
  input  exe_pkg::word_t             rdata1,
  input  exe_pkg::word_t             rdata2,
  input  exe_pkg::word_t             current_pc,
  input  exe_pkg::word_t             imm,
  input  logic [exe_pkg::FUN3_W-1:0] fun3,
  input  logic                       branch,
  input  logic                       jump,
  input  logic                       jal,
  output logic                       taken,
  output exe_pkg::word_t             pc_jump,
  output logic                       inst_addr_misaligned
);
  import exe_pkg::*;

  branch_fun3_t cond;
  logic         eq;
  logic         lt_signed;
  logic         lt_unsigned;
  logic         cond_met;
  logic         jalr;
  word_t        base;
  word_t        target;

  assign cond        = branch_fun3_t'(fun3);
  assign eq          = (rdata1 == rdata2);
  assign lt_signed   = $signed(rdata1) < $signed(rdata2);
  assign lt_unsigned = rdata1 < rdata2;

  always_comb begin
    case (cond)
      BR_EQ:   cond_met = eq;
      BR_NE:   cond_met = ~eq;
      BR_LT:   cond_met = lt_signed;
      BR_GE:   cond_met = ~lt_signed;
      BR_LTU:  cond_met = lt_unsigned;
      BR_GEU:  cond_met = ~lt_unsigned;
      default: cond_met = 1'b0;
    endcase
  end

  // jalr is relative to rs1, everything else to the pc
  assign jalr    = jump & ~jal;
  assign base    = jalr ? rdata1 : current_pc;
  assign target  = base + imm;
  assign pc_jump = jalr ? {target[XLEN-1:1], 1'b0} : target;

  assign taken                = jump | (branch & cond_met);
  assign inst_addr_misaligned = taken & pc_jump[1];

endmodule : branch_unit

/* rtl/execute_stage.sv */
// Execute stage with operand forwarding, ALU, branch resolution and EX/MEM register
module execute_stage (
  input  logic                             clk,
  input  logic                             reset_n,
  // ID/EX data
  input  exe_pkg::word_t                   current_pc,
  input  exe_pkg::word_t                   pc_plus_4,
  input  exe_pkg::reg_idx_t                rs1,
  input  exe_pkg::reg_idx_t                rs2,
  input  exe_pkg::reg_idx_t                rd,
  input  logic [exe_pkg::FUN3_W-1:0]       fun3,
  input  logic [exe_pkg::FUN7_W-1:0]       fun7,
  input  exe_pkg::word_t                   reg_rdata1,
  input  exe_pkg::word_t                   reg_rdata2,
  input  exe_pkg::word_t                   imm,
  // ID/EX control
  input  logic                             reg_write,
  input  logic                             mem_write,
  input  logic [exe_pkg::MEM_TO_REG_W-1:0] mem_to_reg,
  input  logic                             branch,
  input  logic                             alu_src,
  input  logic                             jump,
  input  logic                             jal,
  input  logic                             lui,
  input  logic                             auipc,
  input  exe_pkg::alu_op_t                 alu_op,
  // Forwarding sources
  input  exe_pkg::reg_idx_t                mem_fwd_rd,
  input  logic                             mem_fwd_reg_write,
  input  exe_pkg::word_t                   mem_fwd_data,
  input  exe_pkg::reg_idx_t                wb_rd,
  input  logic                             wb_reg_write,
  input  exe_pkg::word_t                   wb_data,
  input  logic                             stall,
  input  logic                             flush,
  // EX/MEM
  output exe_pkg::word_t                   ex_mem_alu_result,
  output exe_pkg::word_t                   ex_mem_pc_plus_4,
  output exe_pkg::word_t                   ex_mem_pc_jump,
  output exe_pkg::word_t                   ex_mem_rdata2_frw,
  output exe_pkg::reg_idx_t                ex_mem_rd,
  output logic [exe_pkg::FUN3_W-1:0]       ex_mem_fun3,
  output logic                             ex_mem_reg_write,
  output logic                             ex_mem_mem_write,
  output logic [exe_pkg::MEM_TO_REG_W-1:0] ex_mem_mem_to_reg,
  output logic                             ex_mem_pc_sel,
  output logic                             ex_mem_inst_addr_misaligned
);
  import exe_pkg::*;

  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  fwd_sel_t sel_op_a;
  fwd_sel_t sel_op_b;
  word_t    rdata1_frw;
  word_t    rdata2_frw;
  word_t    op_a;
  word_t    op_b;
  word_t    alu_result;
  word_t    pc_jump;
  alu_t     alu_sel;
  logic     taken;
  logic     inst_addr_misaligned;
  logic     wen;

  assign wen = ~stall;

  forwarding_unit i_forwarding_unit (
    .rs1, .rs2, .mem_fwd_rd, .mem_fwd_reg_write, .wb_rd, .wb_reg_write, .fwd_a, .fwd_b
  );

  mux3x1 #(.WIDTH(XLEN)) i_fwd_mux_a (
    .sel(fwd_a), .in0(reg_rdata1), .in1(mem_fwd_data), .in2(wb_data), .out(rdata1_frw)
  );
  mux3x1 #(.WIDTH(XLEN)) i_fwd_mux_b (
    .sel(fwd_b), .in0(reg_rdata2), .in1(mem_fwd_data), .in2(wb_data), .out(rdata2_frw)
  );

  // Operand muxes only ever use the first two inputs
  assign sel_op_a = auipc ? FWD_MEM : FWD_NONE;
  assign sel_op_b = alu_src ? FWD_MEM : FWD_NONE;

  mux3x1 #(.WIDTH(XLEN)) i_op_mux_a (
    .sel(sel_op_a), .in0(rdata1_frw), .in1(current_pc), .in2('0), .out(op_a)
  );
  mux3x1 #(.WIDTH(XLEN)) i_op_mux_b (
    .sel(sel_op_b), .in0(rdata2_frw), .in1(imm), .in2('0), .out(op_b)
  );

  alu_control i_alu_control (.alu_op, .fun3, .fun7, .lui, .alu_sel);

  alu i_alu (.op_a, .op_b, .alu_sel, .result(alu_result));

  branch_unit i_branch_unit (
    .rdata1(rdata1_frw), .rdata2(rdata2_frw), .current_pc, .imm, .fun3, .branch, .jump,
    .jal, .taken, .pc_jump, .inst_addr_misaligned
  );

  // EX/MEM payload
  n_bit_reg #(.WIDTH(XLEN)) i_reg_alu_result (
    .clk, .reset_n, .wen, .data_i(alu_result), .data_o(ex_mem_alu_result)
  );
  n_bit_reg #(.WIDTH(XLEN)) i_reg_pc_plus_4 (
    .clk, .reset_n, .wen, .data_i(pc_plus_4), .data_o(ex_mem_pc_plus_4)
  );
  n_bit_reg #(.WIDTH(XLEN)) i_reg_pc_jump (
    .clk, .reset_n, .wen, .data_i(pc_jump), .data_o(ex_mem_pc_jump)
  );
  n_bit_reg #(.WIDTH(XLEN)) i_reg_rdata2_frw (
    .clk, .reset_n, .wen, .data_i(rdata2_frw), .data_o(ex_mem_rdata2_frw)
  );
  n_bit_reg #(.WIDTH(REG_IDX_W)) i_reg_rd (
    .clk, .reset_n, .wen, .data_i(rd), .data_o(ex_mem_rd)
  );
  n_bit_reg #(.WIDTH(FUN3_W)) i_reg_fun3 (
    .clk, .reset_n, .wen, .data_i(fun3), .data_o(ex_mem_fun3)
  );

  // EX/MEM control, flush turns these into a bubble
  n_bit_reg_wclr #(.WIDTH(1)) i_reg_reg_write (
    .clk, .reset_n, .wen, .data_i(reg_write), .data_o(ex_mem_reg_write), .clear(flush)
  );
  n_bit_reg_wclr #(.WIDTH(1)) i_reg_mem_write (
    .clk, .reset_n, .wen, .data_i(mem_write), .data_o(ex_mem_mem_write), .clear(flush)
  );
  n_bit_reg_wclr #(.WIDTH(MEM_TO_REG_W)) i_reg_mem_to_reg (
    .clk, .reset_n, .wen, .data_i(mem_to_reg), .data_o(ex_mem_mem_to_reg), .clear(flush)
  );
  n_bit_reg_wclr #(.WIDTH(1)) i_reg_pc_sel (
    .clk, .reset_n, .wen, .data_i(taken), .data_o(ex_mem_pc_sel), .clear(flush)
  );
  n_bit_reg_wclr #(.WIDTH(1)) i_reg_misaligned (
    .clk, .reset_n, .wen, .data_i(inst_addr_misaligned),
    .data_o(ex_mem_inst_addr_misaligned), .clear(flush)
  );

endmodule : execute_stage

/* tests/clock_gen.sv */
// Testbench clock and reset generator with a 10 ns clock and 4 cycles of reset
module clock_gen (
  output logic clk,
  output logic reset_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    reset_n = 1'b0;
    repeat (4) @(posedge clk);
    #2 reset_n = 1'b1;
  end

endmodule : clock_gen

/* tests/execute_stage_props.sv */
// Bound assertions on reset, flush and stall behavior of the EX/MEM register
module execute_stage_props (
  input logic                              clk,
  input logic                              reset_n,
  input logic                              stall,
  input logic                              flush,
  input exe_pkg::word_t                    ex_mem_alu_result,
  input exe_pkg::word_t                    ex_mem_pc_plus_4,
  input exe_pkg::word_t                    ex_mem_pc_jump,
  input exe_pkg::word_t                    ex_mem_rdata2_frw,
  input exe_pkg::reg_idx_t                 ex_mem_rd,
  input logic [exe_pkg::FUN3_W-1:0]        ex_mem_fun3,
  input logic                              ex_mem_reg_write,
  input logic                              ex_mem_mem_write,
  input logic [exe_pkg::MEM_TO_REG_W-1:0]  ex_mem_mem_to_reg,
  input logic                              ex_mem_pc_sel,
  input logic                              ex_mem_inst_addr_misaligned
);
  timeunit 1ns;
  timeprecision 1ps;

  reset_clears_control: assert property (@(posedge clk)
    !reset_n |-> !ex_mem_reg_write && !ex_mem_mem_write && !ex_mem_pc_sel)
    else $error("control outputs set during reset");

  flush_gives_bubble: assert property (@(posedge clk) disable iff (!reset_n)
    flush |=> !ex_mem_reg_write && !ex_mem_pc_sel)
    else $error("flush did not clear control outputs");

  // Data holds under stall, control only when no flush comes along
  stall_holds_data: assert property (@(posedge clk) disable iff (!reset_n)
    stall |=> $stable(ex_mem_alu_result) && $stable(ex_mem_pc_plus_4) &&
      $stable(ex_mem_pc_jump) && $stable(ex_mem_rdata2_frw) && $stable(ex_mem_rd) &&
      $stable(ex_mem_fun3))
    else $error("data output changed during stall");

  stall_holds_control: assert property (@(posedge clk) disable iff (!reset_n)
    stall && !flush |=> $stable(ex_mem_reg_write) && $stable(ex_mem_mem_write) &&
      $stable(ex_mem_mem_to_reg) && $stable(ex_mem_pc_sel) &&
      $stable(ex_mem_inst_addr_misaligned))
    else $error("control output changed during stall");

  misaligned_needs_taken: assert property (@(posedge clk) disable iff (!reset_n)
    ex_mem_inst_addr_misaligned |-> ex_mem_pc_sel)
    else $error("misaligned flag without taken branch");

endmodule : execute_stage_props

bind execute_stage execute_stage_props i_execute_stage_props (.*);

/* tests/execute_stage_tb.sv */
// Table-driven testbench for the execute stage with a reference model and summary
module execute_stage_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import exe_pkg::*;

  typedef struct {
    string    name;
    word_t    pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic [2:0] fun3;
    logic [6:0] fun7;
    word_t    rdata1;
    word_t    rdata2;
    word_t    imm;
    logic     reg_write;
    logic     mem_write;
    logic [MEM_TO_REG_W-1:0] mem_to_reg;
    logic     branch;
    logic     alu_src;
    logic     jump;
    logic     jal;
    logic     lui;
    logic     auipc;
    alu_op_t  alu_op;
    reg_idx_t mem_rd;
    logic     mem_we;
    word_t    mem_data;
    reg_idx_t wb_rd_i;
    logic     wb_we;
    word_t    wb_data_i;
    logic     stall;
    logic     flush;
    word_t    exp_result;
    word_t    exp_pc_plus_4;
    word_t    exp_pc_jump;
    word_t    exp_rdata2;
    reg_idx_t exp_rd;
    logic [2:0] exp_fun3;
    logic     exp_pc_sel;
    logic     exp_reg_write;
    logic     exp_mem_write;
    logic [MEM_TO_REG_W-1:0] exp_mem_to_reg;
    logic     exp_misaligned;
  } row_t;

  logic clk;
  logic reset_n;
  word_t current_pc, pc_plus_4, reg_rdata1, reg_rdata2, imm, mem_fwd_data, wb_data;
  reg_idx_t rs1, rs2, rd, mem_fwd_rd, wb_rd;
  logic [FUN3_W-1:0] fun3;
  logic [FUN7_W-1:0] fun7;
  logic [MEM_TO_REG_W-1:0] mem_to_reg;
  logic reg_write, mem_write, branch, alu_src, jump, jal, lui, auipc;
  logic mem_fwd_reg_write, wb_reg_write, stall, flush;
  alu_op_t alu_op;
  word_t ex_mem_alu_result, ex_mem_pc_plus_4, ex_mem_pc_jump, ex_mem_rdata2_frw;
  reg_idx_t ex_mem_rd;
  logic [FUN3_W-1:0] ex_mem_fun3;
  logic [MEM_TO_REG_W-1:0] ex_mem_mem_to_reg;
  logic ex_mem_reg_write, ex_mem_mem_write, ex_mem_pc_sel, ex_mem_inst_addr_misaligned;

  row_t rows[$];
  row_t reset_exp;
  int   errors;
  int   row_errors;
  int   failed_rows;
  int   cycles;
  int   cycle_limit;

  clock_gen i_clock_gen (.clk, .reset_n);

  execute_stage i_execute_stage (.*);

  function automatic word_t alu_model(alu_op_t op, logic [2:0] f3, logic [6:0] f7,
                                      logic is_lui, word_t a, word_t b);
    logic alt;
    if (op == ALU_OP_ADD) return is_lui ? b : a + b;
    if (op == ALU_OP_BRANCH) return a - b;
    // srai is the only I-type that honors fun7
    alt = f7[5] && (op == ALU_OP_RTYPE || f3 == 3'b101);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return word_t'($signed(a) < $signed(b));
      3'd3: return word_t'(a < b);
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic cond_model(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t forwarded(reg_idx_t src, word_t reg_val, row_t r);
    if (r.mem_we && r.mem_rd != 0 && r.mem_rd == src) return r.mem_data;
    if (r.wb_we && r.wb_rd_i != 0 && r.wb_rd_i == src) return r.wb_data_i;
    return reg_val;
  endfunction

  // Fills the expected fields from the row and the previous expected state
  function automatic row_t predict(row_t r, row_t prev);
    word_t a;
    word_t b;
    word_t target;
    logic  taken;
    a = forwarded(r.rs1, r.rdata1, r);
    b = forwarded(r.rs2, r.rdata2, r);
    target = (r.jump && !r.jal) ? ((a + r.imm) & ~32'h1) : r.pc + r.imm;
    taken = r.jump || (r.branch && cond_model(r.fun3, a, b));
    if (r.stall) begin
      r.exp_result = prev.exp_result;
      r.exp_pc_plus_4 = prev.exp_pc_plus_4;
      r.exp_pc_jump = prev.exp_pc_jump;
      r.exp_rdata2 = prev.exp_rdata2;
      r.exp_rd = prev.exp_rd;
      r.exp_fun3 = prev.exp_fun3;
      r.exp_pc_sel = prev.exp_pc_sel;
      r.exp_reg_write = prev.exp_reg_write;
      r.exp_mem_write = prev.exp_mem_write;
      r.exp_mem_to_reg = prev.exp_mem_to_reg;
      r.exp_misaligned = prev.exp_misaligned;
    end else begin
      r.exp_result = alu_model(r.alu_op, r.fun3, r.fun7, r.lui,
                               r.auipc ? r.pc : a, r.alu_src ? r.imm : b);
      r.exp_pc_plus_4 = r.pc + 4;
      r.exp_pc_jump = target;
      r.exp_rdata2 = b;
      r.exp_rd = r.rd;
      r.exp_fun3 = r.fun3;
      r.exp_pc_sel = taken;
      r.exp_reg_write = r.reg_write;
      r.exp_mem_write = r.mem_write;
      r.exp_mem_to_reg = r.mem_to_reg;
      r.exp_misaligned = taken && target[1];
    end
    if (r.flush) begin
      r.exp_pc_sel = 1'b0;
      r.exp_reg_write = 1'b0;
      r.exp_mem_write = 1'b0;
      r.exp_mem_to_reg = '0;
      r.exp_misaligned = 1'b0;
    end
    return r;
  endfunction

  function automatic row_t blank_row(string label);
    row_t r;
    r = '{name: label, alu_op: ALU_OP_RTYPE, default: '0};
    r.pc = 32'h0000_0100;
    r.rs1 = 5'd1;
    r.rs2 = 5'd2;
    r.rd = 5'd3;
    r.reg_write = 1'b1;
    return r;
  endfunction

  task automatic add_row(row_t r);
    row_t prev;
    if (rows.size() == 0) begin
      prev = reset_exp;
    end else begin
      prev = rows[$];
    end
    rows.push_back(predict(r, prev));
  endtask

  task automatic build_table();
    row_t r;
    int f3;
    r = blank_row("lui");
    r.alu_op = ALU_OP_ADD;
    r.lui = 1'b1;
    r.alu_src = 1'b1;
    r.imm = 32'h1234_5000;
    add_row(r);
    r = blank_row("auipc");
    r.alu_op = ALU_OP_ADD;
    r.auipc = 1'b1;
    r.alu_src = 1'b1;
    r.imm = 32'h0000_2000;
    add_row(r);
    // R-type over every fun3, then the fun7 variants
    for (int i = 0; i < 10; i++) begin
      r = blank_row($sformatf("rtype_%0d", i));
      r.fun3 = (i < 8) ? 3'(i) : ((i == 8) ? 3'd0 : 3'd5);
      r.fun7 = (i >= 8) ? 7'h20 : 7'h00;
      r.rdata1 = $urandom();
      r.rdata2 = $urandom();
      // Opposite signs tell the signed and unsigned compares apart
      if (i == 2 || i == 3) begin
        r.rdata1[31] = 1'b1;
        r.rdata2[31] = 1'b0;
      end
      add_row(r);
    end
    r = blank_row("addi_fun7");
    r.alu_op = ALU_OP_ITYPE;
    r.alu_src = 1'b1;
    r.fun7 = 7'h20;
    r.rdata1 = 32'd50;
    r.imm = 32'hffff_fc05;
    add_row(r);
    r = blank_row("srai");
    r.alu_op = ALU_OP_ITYPE;
    r.alu_src = 1'b1;
    r.fun3 = 3'd5;
    r.fun7 = 7'h20;
    r.rdata1 = 32'h8000_0f00;
    r.imm = 32'h0000_0404;
    add_row(r);
    r = blank_row("fwd_mem_over_wb");
    r.rs1 = 5'd5;
    r.rs2 = 5'd6;
    r.mem_rd = 5'd5;
    r.mem_we = 1'b1;
    r.mem_data = 32'h111;
    r.wb_rd_i = 5'd5;
    r.wb_we = 1'b1;
    r.wb_data_i = 32'h222;
    r.rdata1 = 32'h7;
    add_row(r);
    r = blank_row("fwd_wb");
    r.rs2 = 5'd6;
    r.wb_rd_i = 5'd6;
    r.wb_we = 1'b1;
    r.wb_data_i = 32'h333;
    r.rdata1 = 32'h10;
    r.rdata2 = 32'h9;
    add_row(r);
    r = blank_row("fwd_rd_zero");
    r.rs1 = 5'd0;
    r.mem_rd = 5'd0;
    r.mem_we = 1'b1;
    r.mem_data = 32'hdead;
    r.rdata1 = 32'h0;
    r.rdata2 = 32'h4;
    add_row(r);
    r = blank_row("fwd_no_write");
    r.rs1 = 5'd7;
    r.mem_rd = 5'd7;
    r.wb_rd_i = 5'd7;
    r.mem_data = 32'h55;
    r.wb_data_i = 32'h66;
    r.rdata1 = 32'h20;
    r.rdata2 = 32'h1;
    add_row(r);
    // Operand pairs that make each condition both taken and not taken
    for (int p = 0; p < 3; p++) begin
      for (int c = 0; c < 6; c++) begin
        f3 = (c < 2) ? c : c + 2;
        r = blank_row($sformatf("branch_%0d_%0d", p, f3));
        r.alu_op = ALU_OP_BRANCH;
        r.branch = 1'b1;
        r.reg_write = 1'b0;
        r.fun3 = 3'(f3);
        r.pc = 32'h200;
        r.imm = 32'h40;
        r.rdata1 = (p == 0) ? 32'hffff_ffff : ((p == 1) ? 32'h5 : 32'h1);
        r.rdata2 = (p == 0) ? 32'h1 : ((p == 1) ? 32'h5 : 32'hffff_ffff);
        add_row(r);
      end
    end
    r = blank_row("jal");
    r.alu_op = ALU_OP_ADD;
    r.jump = 1'b1;
    r.jal = 1'b1;
    r.alu_src = 1'b1;
    r.mem_to_reg = 2'd2;
    r.pc = 32'h300;
    r.imm = 32'h10;
    add_row(r);
    r = blank_row("jalr");
    r.alu_op = ALU_OP_ADD;
    r.jump = 1'b1;
    r.alu_src = 1'b1;
    r.mem_to_reg = 2'd2;
    r.rdata1 = 32'h1001;
    r.imm = 32'h20;
    add_row(r);
    r = blank_row("jal_misaligned");
    r.alu_op = ALU_OP_ADD;
    r.jump = 1'b1;
    r.jal = 1'b1;
    r.alu_src = 1'b1;
    r.mem_to_reg = 2'd2;
    r.pc = 32'h300;
    r.imm = 32'h12;
    add_row(r);
    r = blank_row("stall");
    r.stall = 1'b1;
    r.rd = 5'd9;
    r.rdata1 = 32'h99;
    r.mem_write = 1'b1;
    r.mem_to_reg = 2'd1;
    add_row(r);
    r = blank_row("flush");
    r.flush = 1'b1;
    r.rd = 5'd11;
    r.mem_write = 1'b1;
    r.mem_to_reg = 2'd1;
    r.jump = 1'b1;
    r.jal = 1'b1;
    r.rdata1 = 32'h40;
    r.rdata2 = 32'h2;
    add_row(r);
    r = blank_row("store");
    r.alu_op = ALU_OP_ADD;
    r.alu_src = 1'b1;
    r.mem_write = 1'b1;
    r.reg_write = 1'b0;
    r.rdata1 = 32'h1000;
    r.imm = 32'h8;
    add_row(r);
    r = blank_row("flush_stall");
    r.flush = 1'b1;
    r.stall = 1'b1;
    r.rd = 5'd12;
    r.rdata1 = 32'h77;
    add_row(r);
  endtask

  task automatic drive_row(row_t r);
    current_pc = r.pc;
    pc_plus_4 = r.pc + 4;
    rs1 = r.rs1;
    rs2 = r.rs2;
    rd = r.rd;
    fun3 = r.fun3;
    fun7 = r.fun7;
    reg_rdata1 = r.rdata1;
    reg_rdata2 = r.rdata2;
    imm = r.imm;
    reg_write = r.reg_write;
    mem_write = r.mem_write;
    mem_to_reg = r.mem_to_reg;
    branch = r.branch;
    alu_src = r.alu_src;
    jump = r.jump;
    jal = r.jal;
    lui = r.lui;
    auipc = r.auipc;
    alu_op = r.alu_op;
    mem_fwd_rd = r.mem_rd;
    mem_fwd_reg_write = r.mem_we;
    mem_fwd_data = r.mem_data;
    wb_rd = r.wb_rd_i;
    wb_reg_write = r.wb_we;
    wb_data = r.wb_data_i;
    stall = r.stall;
    flush = r.flush;
  endtask

  task automatic check_word(string field, word_t got, word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %0t: %s got %h expected %h", $time, field, got, exp);
      row_errors++;
    end
  endtask

  task automatic check_idx(string field, reg_idx_t got, reg_idx_t exp);
    if (got !== exp) begin
      $display("MISMATCH %0t: %s got %0d expected %0d", $time, field, got, exp);
      row_errors++;
    end
  endtask

  task automatic check_fun3(string field, logic [FUN3_W-1:0] got, logic [FUN3_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %0t: %s got %b expected %b", $time, field, got, exp);
      row_errors++;
    end
  endtask

  task automatic check_mem_to_reg(string field, logic [MEM_TO_REG_W-1:0] got,
                                  logic [MEM_TO_REG_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %0t: %s got %b expected %b", $time, field, got, exp);
      row_errors++;
    end
  endtask

  task automatic check_bit(string field, logic got, logic exp);
    if (got !== exp) begin
      $display("MISMATCH %0t: %s got %b expected %b", $time, field, got, exp);
      row_errors++;
    end
  endtask

  task automatic check_row(row_t r);
    row_errors = 0;
    check_word("ex_mem_alu_result", ex_mem_alu_result, r.exp_result);
    check_word("ex_mem_pc_plus_4", ex_mem_pc_plus_4, r.exp_pc_plus_4);
    check_word("ex_mem_pc_jump", ex_mem_pc_jump, r.exp_pc_jump);
    check_word("ex_mem_rdata2_frw", ex_mem_rdata2_frw, r.exp_rdata2);
    check_idx("ex_mem_rd", ex_mem_rd, r.exp_rd);
    check_fun3("ex_mem_fun3", ex_mem_fun3, r.exp_fun3);
    check_bit("ex_mem_pc_sel", ex_mem_pc_sel, r.exp_pc_sel);
    check_bit("ex_mem_reg_write", ex_mem_reg_write, r.exp_reg_write);
    check_bit("ex_mem_mem_write", ex_mem_mem_write, r.exp_mem_write);
    check_mem_to_reg("ex_mem_mem_to_reg", ex_mem_mem_to_reg, r.exp_mem_to_reg);
    check_bit("ex_mem_inst_addr_misaligned", ex_mem_inst_addr_misaligned,
              r.exp_misaligned);
    errors += row_errors;
    if (row_errors != 0) failed_rows++;
    $display("row %s: %s", r.name, (row_errors == 0) ? "ok" : "failed");
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hd193));
    errors = 0;
    failed_rows = 0;
    cycles = 0;
    reset_exp = '{name: "reset", alu_op: ALU_OP_ADD, default: '0};
    drive_row(blank_row("idle"));
    reg_write = 1'b0;
    build_table();
    cycle_limit = rows.size() * 4 + 20;
    @(posedge reset_n);
    #1;
    check_row(reset_exp);
    foreach (rows[i]) begin
      @(posedge clk);
      #1;
      if (i > 0) check_row(rows[i-1]);
      drive_row(rows[i]);
    end
    @(posedge clk);
    #1;
    check_row(rows[$]);
    $display("rows %0d, failed %0d, mismatches %0d", rows.size() + 1, failed_rows, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : execute_stage_tb

/* list.f */
rtl/exe_pkg.sv
rtl/common_cells.sv
rtl/forwarding_unit.sv
rtl/alu_control.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/execute_stage.sv
tests/clock_gen.sv
tests/execute_stage_props.sv
tests/execute_stage_tb.sv
